/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := uio_loop_tb
RTL_TOP    := uio_loop
FILELIST   := uio_loop.f
BUILD_DIR  := obj_dir
SIM_LOG    := sim.log
SIM_ARGS   := +verilator+error+limit+1000
PASS_MSG   := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, the exit code of the model is not used
run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(SIM_LOG) 2>&1 || true
	@cat $(SIM_LOG)
	@grep -q "$(PASS_MSG)" $(SIM_LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)

/* bench/uio_loop_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module uio_loop_chk
   import uio_pkg::*;
(
   input wire                            clk_per,
   input wire                            i_rst_n,
   input wire uio_beat_s [UIO_PORTS-1:0] i_rq,
   input wire [UIO_PORTS-1:0]            o_rq_afull,
   input wire uio_beat_s [UIO_PORTS-1:0] o_rs,
   input wire [UIO_PORTS-1:0]            i_rs_afull,
   input wire csr_req_s                  i_csr,
   input wire csr_rsp_s                  o_csr
);

   int fail_count = 0;

   for (genvar p = 0; p < UIO_PORTS; p++) begin : g_port
      logic [3:0] afull_run;

      // Saturating count of cycles with request almost-full high
      always_ff @(posedge clk_per or negedge i_rst_n) begin
         if (!i_rst_n) begin
            afull_run <= '0;
         end else if (!o_rq_afull[p]) begin
            afull_run <= '0;
         end else if (afull_run != 4'hf) begin
            afull_run <= afull_run + 1'b1;
         end
      end

      a_rs_gated: assert property (@(posedge clk_per) disable iff (!i_rst_n)
         !(o_rs[p].vld && i_rs_afull[p]))
      else begin
         $error("port %0d offered a word while its consumer was almost full", p);
         fail_count = fail_count + 1;
      end

      // Six late beats fit in the margin and a seventh would overflow
      a_rq_stopped: assert property (@(posedge clk_per) disable iff (!i_rst_n)
         !(i_rq[p].vld && o_rq_afull[p] && afull_run >= 4'd6))
      else begin
         $error("port %0d got a request long after raising almost-full", p);
         fail_count = fail_count + 1;
      end
   end

   a_ack_after_rd: assert property (@(posedge clk_per) disable iff (!i_rst_n)
      i_csr.rd_vld |=> o_csr.rd_ack)
   else begin
      $error("CSR read was not acknowledged one cycle later");
      fail_count = fail_count + 1;
   end

   a_ack_only_after_rd: assert property (@(posedge clk_per) disable iff (!i_rst_n)
      !i_csr.rd_vld |=> !o_csr.rd_ack)
   else begin
      $error("CSR acknowledge without a read one cycle earlier");
      fail_count = fail_count + 1;
   end

endmodule : uio_loop_chk

bind uio_loop uio_loop_chk chk_i (
   .clk_per    (clk_per),
   .i_rst_n    (i_rst_n),
   .i_rq       (i_rq),
   .o_rq_afull (o_rq_afull),
   .o_rs       (o_rs),
   .i_rs_afull (i_rs_afull),
   .i_csr      (i_csr),
   .o_csr      (o_csr)
);

`default_nettype wire

/* bench/uio_loop_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module uio_loop_tb
   import uio_pkg::*;
();

   localparam int NUM_TESTS   = 10;
   localparam int DRAIN_LIMIT = 400;
   localparam int SEND_LIMIT  = 600;
   localparam int ACK_LIMIT   = 4;

   typedef enum logic [2:0] {
      K_RESET, K_LOOP, K_BACKPRESS, K_CSR_RD, K_CSR_WR, K_CSR_BAD, K_ALL
   } kind_e;

   typedef struct packed {
      logic [8*16-1:0]       name;
      kind_e                 kind;
      logic [UIO_PORTS-1:0]  mask;
      logic [7:0]            count;
      logic [UIO_PORTS-1:0]  bp;
      logic [CSR_ADDR_W-1:0] addr;
      logic [CSR_DATA_W-1:0] wdata;
      logic [CSR_DATA_W-1:0] rdata;
   } test_s;

   logic                      clk_per;
   logic                      rst_n;
   uio_beat_s [UIO_PORTS-1:0] rq;
   logic [UIO_PORTS-1:0]      rs_afull;
   csr_req_s                  csr_req;
   wire uio_beat_s [UIO_PORTS-1:0] rs;
   wire [UIO_PORTS-1:0]       rq_afull;
   wire csr_rsp_s             csr_rsp;

   test_s                 tests [NUM_TESTS];
   uio_word_t             exp_q [UIO_PORTS][$];
   int                    drive_cyc_q [UIO_PORTS][$];
   int                    first_lat [UIO_PORTS];
   logic [CSR_DATA_W-1:0] scratch_model [2];
   logic [31:0]           lfsr_state;
   int                    cyc = 0;
   int                    err_count = 0;
   int                    tests_passed = 0;
   int                    tests_failed = 0;

   initial begin
      clk_per = 1'b0;
      forever #2 clk_per = ~clk_per;
   end

   always @(posedge clk_per) begin
      cyc <= cyc + 1;
   end

   uio_loop uio_loop_i (
      .clk_per    (clk_per),
      .i_rst_n    (rst_n),
      .i_rq       (rq),
      .o_rq_afull (rq_afull),
      .o_rs       (rs),
      .i_rs_afull (rs_afull),
      .i_csr      (csr_req),
      .o_csr      (csr_rsp)
   );

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int b = 0; b < n; b++) begin
         r = {r[30:0], lfsr_state[0]};
         if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
         end else begin
            lfsr_state = lfsr_state >> 1;
         end
      end
      return r;
   endfunction

   function automatic test_s make_test(input logic [127:0] name, input kind_e kind,
                                        input logic [3:0] mask, input logic [7:0] count,
                                        input logic [3:0] bp, input logic [15:0] addr,
                                        input logic [63:0] wdata, input logic [63:0] rdata);
      test_s t;
      t.name  = name;
      t.kind  = kind;
      t.mask  = mask;
      t.count = count;
      t.bp    = bp;
      t.addr  = addr;
      t.wdata = wdata;
      t.rdata = rdata;
      return t;
   endfunction

   // Skip the zero padding in front of short names
   function automatic string name_of(input logic [127:0] v);
      string s;
      s = "";
      for (int i = 15; i >= 0; i--) begin
         if (v[i*8 +: 8] != 8'h00) begin
            s = $sformatf("%s%c", s, v[i*8 +: 8]);
         end
      end
      return s;
   endfunction

   function automatic int first_port(input logic [UIO_PORTS-1:0] mask);
      for (int p = 0; p < UIO_PORTS; p++) begin
         if (mask[p]) begin
            return p;
         end
      end
      return 0;
   endfunction

   function automatic int outstanding();
      int n;
      n = 0;
      for (int p = 0; p < UIO_PORTS; p++) begin
         n += exp_q[p].size();
      end
      return n;
   endfunction

   task automatic check_value(input string sig, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
      if (act_v !== exp_v) begin
         $display("Fail at %0t ns: %s expected %h, got %h", $time, sig, exp_v, act_v);
         err_count++;
      end
   endtask

   task automatic report_error(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      err_count++;
   endtask

   // Response monitor samples mid-cycle where o_rs is settled
   always @(negedge clk_per) begin
      uio_word_t exp_w;
      int        lat;
      if (rst_n) begin
         for (int p = 0; p < UIO_PORTS; p++) begin
            if (rs[p].vld && rs_afull[p]) begin
               report_error($sformatf("port %0d valid while consumer almost full", p));
            end
            if (rs[p].vld) begin
               if (exp_q[p].size() == 0) begin
                  report_error($sformatf("word %h on port %0d was never sent", rs[p].data, p));
               end else begin
                  exp_w = exp_q[p].pop_front();
                  lat   = cyc - drive_cyc_q[p].pop_front();
                  check_value($sformatf("o_rs[%0d].data", p), 64'(exp_w), 64'(rs[p].data));
                  if (first_lat[p] < 0) begin
                     first_lat[p] = lat;
                  end
               end
            end
         end
      end
   end

   // Every driver step ends 1 ns after a rising edge
   task automatic next_cycle();
      @(posedge clk_per);
      #1;
   endtask

   task automatic send_word(input int p);
      uio_word_t w;
      w = rand_bits(32);
      rq[p].vld  = 1'b1;
      rq[p].data = w;
      exp_q[p].push_back(w);
      drive_cyc_q[p].push_back(cyc);
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (outstanding() > 0 && n < DRAIN_LIMIT) begin
         next_cycle();
         n++;
      end
      for (int p = 0; p < UIO_PORTS; p++) begin
         if (exp_q[p].size() > 0) begin
            report_error($sformatf("timeout, %0d words sent on port %0d never came back",
                                   exp_q[p].size(), p));
            exp_q[p].delete();
            drive_cyc_q[p].delete();
         end
      end
      // A few idle cycles to catch stray words
      repeat (3) next_cycle();
   endtask

   task automatic csr_write(input logic [15:0] addr, input logic [63:0] data);
      csr_req.addr   = addr;
      csr_req.data   = data;
      csr_req.wr_vld = 1'b1;
      next_cycle();
      csr_req.wr_vld = 1'b0;
      if (addr == CSR_SCRATCH_REG0) begin
         scratch_model[0] = data;
      end else if (addr == CSR_SCRATCH_REG1) begin
         scratch_model[1] = data;
      end
   endtask

   task automatic csr_read_check(input logic [15:0] addr, input logic [63:0] exp_v);
      int issue;
      int n;
      csr_req.addr   = addr;
      csr_req.rd_vld = 1'b1;
      issue = cyc;
      next_cycle();
      csr_req.rd_vld = 1'b0;
      n = 0;
      while (!csr_rsp.rd_ack && n < ACK_LIMIT) begin
         next_cycle();
         n++;
      end
      if (!csr_rsp.rd_ack) begin
         report_error($sformatf("no read acknowledge arrived for address %h", addr));
      end else begin
         check_value("o_csr.rd_ack latency", 64'(1), 64'(cyc - issue));
         check_value($sformatf("o_csr.data at %h", addr), exp_v, csr_rsp.data);
      end
   endtask

   task automatic reset_outputs_low();
      for (int p = 0; p < UIO_PORTS; p++) begin
         check_value($sformatf("o_rs[%0d].vld", p), 64'(0), 64'(rs[p].vld));
         check_value($sformatf("o_rq_afull[%0d]", p), 64'(0), 64'(rq_afull[p]));
      end
      check_value("o_csr.rd_ack", 64'(0), 64'(csr_rsp.rd_ack));
   endtask

   task automatic loopback_words(input test_s t);
      for (int p = 0; p < UIO_PORTS; p++) begin
         first_lat[p] = -1;
      end
      for (int i = 0; i < int'(t.count); i++) begin
         for (int p = 0; p < UIO_PORTS; p++) begin
            if (t.mask[p]) begin
               send_word(p);
            end
         end
         next_cycle();
         rq = '0;
      end
      wait_drain();
      for (int p = 0; p < UIO_PORTS; p++) begin
         if (t.mask[p]) begin
            check_value($sformatf("port %0d first word latency", p), 64'(2), 64'(first_lat[p]));
         end
      end
   endtask

   task automatic fill_and_release(input test_s t);
      int p;
      int sent;
      p = first_port(t.mask);
      sent = 0;
      rs_afull = t.bp;
      while (!rq_afull[p] && sent < 2 * UIO_FIFO_DEPTH) begin
         send_word(p);
         next_cycle();
         rq = '0;
         sent++;
      end
      if (!rq_afull[p]) begin
         report_error($sformatf("o_rq_afull[%0d] never rose after %0d words", p, sent));
      end else if (sent < UIO_AFULL_LEVEL) begin
         report_error($sformatf("o_rq_afull[%0d] rose after only %0d words", p, sent));
      end
      repeat (8) next_cycle();
      check_value($sformatf("words held on port %0d", p), 64'(sent), 64'(exp_q[p].size()));
      rs_afull = '0;
      wait_drain();
   endtask

   task automatic random_traffic(input test_s t);
      int          remaining [UIO_PORTS];
      int          n;
      logic [31:0] r;
      for (int p = 0; p < UIO_PORTS; p++) begin
         remaining[p] = t.mask[p] ? int'(t.count) : 0;
      end
      n = 0;
      while ((remaining[0] + remaining[1] + remaining[2] + remaining[3]) > 0
             && n < SEND_LIMIT) begin
         for (int p = 0; p < UIO_PORTS; p++) begin
            r = rand_bits(1);
            rs_afull[p] = t.bp[p] & r[0];
            if (remaining[p] > 0 && !rq_afull[p]) begin
               send_word(p);
               remaining[p]--;
            end
         end
         next_cycle();
         rq = '0;
         n++;
      end
      for (int p = 0; p < UIO_PORTS; p++) begin
         if (remaining[p] > 0) begin
            report_error($sformatf("timeout, port %0d never accepted %0d words", p, remaining[p]));
         end
      end
      rs_afull = '0;
      wait_drain();
   endtask

   initial begin
      int errs_before;
      rst_n      = 1'b0;
      rq         = '0;
      rs_afull   = '0;
      csr_req    = '0;
      lfsr_state = 32'd94289;
      scratch_model[0] = '0;
      scratch_model[1] = '0;
      for (int p = 0; p < UIO_PORTS; p++) begin
         first_lat[p] = -1;
      end

      tests[0] = make_test("reset_state", K_RESET, 4'b0000, 8'd0, 4'b0000, 16'h0, '0, '0);
      tests[1] = make_test("csr_rd_reset0", K_CSR_RD, 4'b0000, 8'd0, 4'b0000,
                           CSR_SCRATCH_REG0, '0, 64'h0);
      tests[2] = make_test("csr_rd_reset1", K_CSR_RD, 4'b0000, 8'd0, 4'b0000,
                           CSR_SCRATCH_REG1, '0, 64'h0);
      tests[3] = make_test("loop_port1", K_LOOP, 4'b0010, 8'd12, 4'b0000, 16'h0, '0, '0);
      tests[4] = make_test("loop_port3", K_LOOP, 4'b1000, 8'd5, 4'b0000, 16'h0, '0, '0);
      tests[5] = make_test("backpressure", K_BACKPRESS, 4'b0100, 8'd0, 4'b0100, 16'h0, '0, '0);
      tests[6] = make_test("csr_scratch0", K_CSR_WR, 4'b0000, 8'd0, 4'b0000, CSR_SCRATCH_REG0,
                           64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef);
      tests[7] = make_test("csr_scratch1", K_CSR_WR, 4'b0000, 8'd0, 4'b0000, CSR_SCRATCH_REG1,
                           64'hfedc_ba98_7654_3210, 64'hfedc_ba98_7654_3210);
      tests[8] = make_test("csr_unmapped", K_CSR_BAD, 4'b0000, 8'd0, 4'b0000, 16'h0010,
                           64'h5a5a_5a5a_a5a5_a5a5, CSR_BAD_ADDR_DATA);
      tests[9] = make_test("all_ports", K_ALL, 4'b1111, 8'd40, 4'b1111, 16'h0, '0, '0);

      repeat (5) @(posedge clk_per);
      #1;
      rst_n = 1'b1;
      next_cycle();

      for (int i = 0; i < NUM_TESTS; i++) begin
         errs_before = err_count;
         case (tests[i].kind)
            K_RESET:     reset_outputs_low();
            K_LOOP:      loopback_words(tests[i]);
            K_BACKPRESS: fill_and_release(tests[i]);
            K_CSR_RD:    csr_read_check(tests[i].addr, tests[i].rdata);
            K_CSR_WR: begin
               csr_write(tests[i].addr, tests[i].wdata);
               csr_read_check(tests[i].addr, tests[i].rdata);
            end
            K_CSR_BAD: begin
               csr_write(tests[i].addr, tests[i].wdata);
               csr_read_check(tests[i].addr, tests[i].rdata);
               csr_read_check(CSR_SCRATCH_REG0, scratch_model[0]);
               csr_read_check(CSR_SCRATCH_REG1, scratch_model[1]);
            end
            K_ALL:       random_traffic(tests[i]);
            default:     report_error("test table holds an unknown test kind");
         endcase
         if (err_count == errs_before) begin
            tests_passed++;
            $display("Test %s passed", name_of(tests[i].name));
         end else begin
            tests_failed++;
            $display("Test %s failed", name_of(tests[i].name));
         end
      end

      $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
               tests_passed, tests_failed, uio_loop_i.chk_i.fail_count);
      if (err_count == 0 && uio_loop_i.chk_i.fail_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule : uio_loop_tb

`default_nettype wire

/* uio_loop.f */
verilog/uio_pkg.sv
verilog/uio_fifo.sv
verilog/uio_lane.sv
verilog/uio_csr.sv
verilog/uio_loop.sv
bench/uio_loop_chk.sv
bench/uio_loop_tb.sv

/* verilog/uio_csr.sv */
`timescale 1ns/1ns
`default_nettype none

module uio_csr
   import uio_pkg::*;
(
   input  wire      clk_per,
   input  wire      i_rst_n,
   input  wire      csr_req_s i_csr,
   output csr_rsp_s o_csr
);

   logic [CSR_DATA_W-1:0] scratch0;
   logic [CSR_DATA_W-1:0] scratch1;
   logic [CSR_DATA_W-1:0] rd_mux;
   logic [CSR_DATA_W-1:0] rd_data;
   logic                  rd_ack;
   logic                  sel0;
   logic                  sel1;

   // Address decode
   assign sel0 = (i_csr.addr == CSR_SCRATCH_REG0);
   assign sel1 = (i_csr.addr == CSR_SCRATCH_REG1);

   // Read select uses the current register values, so a read beside a
   // write in the same cycle sees the old contents
   always_comb begin
      case (1'b1)
         sel0:    rd_mux = scratch0;
         sel1:    rd_mux = scratch1;
         default: rd_mux = CSR_BAD_ADDR_DATA;
      endcase
   end

   // Scratch registers, unmapped writes fall through
   always_ff @(posedge clk_per or negedge i_rst_n) begin
      if (!i_rst_n) begin
         scratch0 <= '0;
         scratch1 <= '0;
      end else if (i_csr.wr_vld) begin
         if (sel0) begin
            scratch0 <= i_csr.data;
         end
         if (sel1) begin
            scratch1 <= i_csr.data;
         end
      end
   end

   // Every read is acked next cycle, mapped or not
   always_ff @(posedge clk_per or negedge i_rst_n) begin
      if (!i_rst_n) begin
         rd_ack <= 1'b0;
      end else begin
         rd_ack <= i_csr.rd_vld;
      end
   end

   always_ff @(posedge clk_per) begin
      if (i_csr.rd_vld) begin
         rd_data <= rd_mux;
      end
   end

   assign o_csr.data   = rd_data;
   assign o_csr.rd_ack = rd_ack;

endmodule : uio_csr

`default_nettype wire

/* verilog/uio_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module uio_fifo
   import uio_pkg::*;
#(
   parameter int WIDTH       = UIO_WIDTH,
   parameter int DEPTH       = UIO_FIFO_DEPTH,
   parameter int AFULL_LEVEL = UIO_AFULL_LEVEL
) (
   input  wire              clk_per,
   input  wire              i_rst_n,

   // Write side
   input  wire              i_push,
   input  wire  [WIDTH-1:0] i_din,

   // Read side, head word always presented
   input  wire              i_pop,
   output logic [WIDTH-1:0] o_dout,

   // Status
   output logic             o_empty,
   output logic             o_full,
   output logic             o_afull
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [CW-1:0]    count;
   logic             do_push;
   logic             do_pop;

   // Wrap at DEPTH so depths other than a power of two work
   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
      if (ptr == AW'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // Overflow and underflow requests are dropped
   assign do_push = i_push && !o_full;
   assign do_pop  = i_pop && !o_empty;

   always_ff @(posedge clk_per or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk_per) begin
      if (do_push) begin
         mem[wr_ptr] <= i_din;
      end
   end

   assign o_dout  = mem[rd_ptr];

   // Flags straight from occupancy
   assign o_empty = (count == '0);
   assign o_full  = (count == CW'(DEPTH));
   assign o_afull = (count >= CW'(AFULL_LEVEL));

endmodule : uio_fifo

`default_nettype wire

/* verilog/uio_lane.sv */
`timescale 1ns/1ns
`default_nettype none

module uio_lane
   import uio_pkg::*;
(
   input  wire       clk_per,
   input  wire       i_rst_n,

   // Request side
   input  wire       uio_beat_s i_rq,
   output logic      o_rq_afull,

   // Response side
   output uio_beat_s o_rs,
   input  wire       i_rs_afull
);

   logic      rq_empty;
   uio_word_t rq_head;
   logic      rs_empty;
   logic      rs_afull;
   logic      xfer;
   logic      rs_pop;
   uio_word_t rs_head;

   // Request FIFO takes every valid beat from the port
   uio_fifo #(
      .WIDTH       (UIO_WIDTH),
      .DEPTH       (UIO_FIFO_DEPTH),
      .AFULL_LEVEL (UIO_AFULL_LEVEL)
   ) rq_fifo_i (
      .clk_per (clk_per),
      .i_rst_n (i_rst_n),
      .i_push  (i_rq.vld),
      .i_din   (i_rq.data),
      .i_pop   (xfer),
      .o_dout  (rq_head),
      .o_empty (rq_empty),
      .o_full  (),
      .o_afull (o_rq_afull)
   );

   // Move one word while the response FIFO is below its level
   assign xfer = !rq_empty && !rs_afull;

   uio_fifo #(
      .WIDTH       (UIO_WIDTH),
      .DEPTH       (UIO_FIFO_DEPTH),
      .AFULL_LEVEL (UIO_AFULL_LEVEL)
   ) rs_fifo_i (
      .clk_per (clk_per),
      .i_rst_n (i_rst_n),
      .i_push  (xfer),
      .i_din   (rq_head),
      .i_pop   (rs_pop),
      .o_dout  (rs_head),
      .o_empty (rs_empty),
      .o_full  (),
      .o_afull (rs_afull)
   );

   // No ready, an offered word is taken
   assign rs_pop    = !rs_empty && !i_rs_afull;
   assign o_rs.vld  = rs_pop;
   assign o_rs.data = rs_head;

endmodule : uio_lane

`default_nettype wire

/* verilog/uio_loop.sv */
`timescale 1ns/1ns
`default_nettype none

module uio_loop
   import uio_pkg::*;
(
   input  wire                             clk_per,
   input  wire                             i_rst_n,

   // Request beats from the sender, one per port
   input  wire  uio_beat_s [UIO_PORTS-1:0] i_rq,
   output wire  [UIO_PORTS-1:0]            o_rq_afull,

   // Response beats toward the consumer
   output wire  uio_beat_s [UIO_PORTS-1:0] o_rs,
   input  wire  [UIO_PORTS-1:0]            i_rs_afull,

   // CSR access
   input  wire  csr_req_s                  i_csr,
   output wire  csr_rsp_s                  o_csr
);

   // One loopback lane per port
   for (genvar p = 0; p < UIO_PORTS; p++) begin : g_lane
      uio_lane lane_i (
         .clk_per    (clk_per),
         .i_rst_n    (i_rst_n),
         .i_rq       (i_rq[p]),
         .o_rq_afull (o_rq_afull[p]),
         .o_rs       (o_rs[p]),
         .i_rs_afull (i_rs_afull[p])
      );
   end

   // Scratch registers and read response
   uio_csr csr_i (
      .clk_per (clk_per),
      .i_rst_n (i_rst_n),
      .i_csr   (i_csr),
      .o_csr   (o_csr)
   );

endmodule : uio_loop

`default_nettype wire

/* verilog/uio_pkg.sv */
`default_nettype none

package uio_pkg;

   // Loopback lanes
   localparam int unsigned UIO_PORTS        = 4;
   localparam int unsigned UIO_WIDTH        = 32;
   localparam int unsigned UIO_FIFO_DEPTH   = 16;

   // Free entries kept for beats still in flight from the sender
   localparam int unsigned UIO_AFULL_MARGIN = 6;
   localparam int unsigned UIO_AFULL_LEVEL  = UIO_FIFO_DEPTH - UIO_AFULL_MARGIN;

   // CSR space
   localparam int unsigned CSR_ADDR_W = 16;
   localparam int unsigned CSR_DATA_W = 64;

   localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH_REG0 = 16'h0000;
   localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH_REG1 = 16'h0008;

   // Marker returned for any unmapped read
   localparam logic [CSR_DATA_W-1:0] CSR_BAD_ADDR_DATA = 64'hdeadbeef_deadbeef;

   typedef logic [UIO_WIDTH-1:0] uio_word_t;

   // Request and response beats share this shape
   typedef struct packed {
      logic      vld;
      uio_word_t data;
   } uio_beat_s;

   typedef struct packed {
      logic [CSR_ADDR_W-1:0] addr;
      logic [CSR_DATA_W-1:0] data;
      logic                  wr_vld;
      logic                  rd_vld;
   } csr_req_s;

   typedef struct packed {
      logic [CSR_DATA_W-1:0] data;
      logic                  rd_ack;
   } csr_rsp_s;

endpackage : uio_pkg

`default_nettype wire
